// File: design/lsu_cmd_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_cmd_gen
  import lsu_pkg::*;
#(
  parameter int RSP_DEPTH = 4
) (
  input  wire logic      clk,
  input  wire logic      rest,
  input  wire logic      req_valid,
  input  wire lsu_req_t  req,
  output logic           req_ready,
  output bus_cmd_t       bus_cmd,
  input  wire logic      bus_ready,
  input  wire logic      credit_return,
  output logic           tag_push,
  output load_tag_t      tag
);

  localparam int CW = $clog2(RSP_DEPTH + 1);

  logic [CW-1:0] credits;
  logic          has_credit;
  logic          cmd_rd;
  logic          cmd_wr;
  logic          cmd_busy;
  logic          cmd_accept;
  logic          reg_free;
  logic          req_fire;
  logic          load_fire;
  logic [31:0]   cmd_addr;
  logic [31:0]   cmd_wdata;
  logic [3:0]    cmd_be;
  load_tag_t     tag_q;

  assign cmd_busy   = cmd_rd | cmd_wr;
  assign cmd_accept = cmd_busy & bus_ready;
  assign reg_free   = !cmd_busy || bus_ready;

  // A credit coming back this cycle may be spent in the same cycle
  assign has_credit = (credits != '0) || credit_return;

  assign req_ready = reg_free && (req.write || has_credit);
  assign req_fire  = req_valid && req_ready;
  assign load_fire = req_fire && !req.write;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      credits <= CW'(RSP_DEPTH);
    end else begin
      if (load_fire && !credit_return) begin
        credits <= credits - 1'b1;
      end else if (!load_fire && credit_return) begin
        credits <= credits + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      cmd_rd <= 1'b0;
      cmd_wr <= 1'b0;
    end else begin
      if (req_fire) begin
        cmd_rd <= !req.write;
        cmd_wr <= req.write;
      end else if (cmd_accept) begin
        cmd_rd <= 1'b0;
        cmd_wr <= 1'b0;
      end
    end
  end

  // Store data is moved into the byte lanes selected by the low address bits
  always_ff @(posedge clk) begin
    if (req_fire) begin
      cmd_addr   <= {req.addr[31:2], 2'b00};
      cmd_be     <= byte_enables(req.op, req.addr[1:0]);
      cmd_wdata  <= req.wdata << {req.addr[1:0], 3'b000};
      tag_q      <= '{offset: req.addr[1:0], op: req.op};
    end
  end

  assign bus_cmd = '{
    address:    cmd_addr,
    read:       cmd_rd,
    write:      cmd_wr,
    byte_en:    cmd_be,
    write_data: cmd_wdata
  };

  // The tag follows the read onto the bus so the aligner sees it in issue order
  assign tag_push = cmd_accept & cmd_rd;
  assign tag      = tag_q;

endmodule

`default_nettype wire

// File: design/lsu_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  wire logic     clk,
  input  wire logic     rest,
  input  wire logic     push,
  input  wire payload_t push_data,
  input  wire logic     pop,
  output payload_t      pop_data,
  output logic          empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Head entry is shown directly from storage
  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);

endmodule

`default_nettype wire

// File: design/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
  import lsu_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rest,
  input  wire logic        tag_empty,
  input  wire load_tag_t   tag,
  input  wire logic        data_empty,
  input  wire logic [31:0] rsp_word,
  output logic             pop,
  output logic             credit_return,
  output logic             load_valid,
  output logic [31:0]      load_data
);

  logic pop_q;
  logic pair_ready;

  assign pair_ready = !tag_empty && !data_empty;

  // The FIFO empty flags lag a pop by one cycle, so a pop is never
  // scheduled while the previous one is still in flight
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      pop_q      <= 1'b0;
      load_valid <= 1'b0;
    end else begin
      pop_q      <= pair_ready && !pop_q;
      load_valid <= pop_q;
    end
  end

  // Tag and word are taken while they sit at the heads of both FIFOs
  always_ff @(posedge clk) begin
    if (pop_q) begin
      load_data <= extend_load(tag.op, tag.offset, rsp_word);
    end
  end

  // Freeing a response entry is what gives the credit back
  assign pop           = pop_q;
  assign credit_return = pop_q;

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // Encoding follows the funct3 field of the RISC-V load and store opcodes
  typedef enum logic [2:0] {
    MEM_OP_B  = 3'b000,
    MEM_OP_H  = 3'b001,
    MEM_OP_W  = 3'b010,
    MEM_OP_BU = 3'b100,
    MEM_OP_HU = 3'b101
  } mem_op_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    mem_op_t     op;
    logic        write;
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [3:0]  byte_en;
    logic [31:0] write_data;
  } bus_cmd_t;

  typedef struct packed {
    logic [1:0] offset;
    mem_op_t    op;
  } load_tag_t;

  function automatic logic [3:0] byte_enables(mem_op_t op, logic [1:0] offset);
    case (op)
      MEM_OP_B, MEM_OP_BU: return 4'b0001 << offset;
      MEM_OP_H, MEM_OP_HU: return 4'b0011 << offset;
      default:             return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] extend_load(mem_op_t op, logic [1:0] offset,
                                              logic [31:0] word);
    logic [31:0] shifted;
    shifted = word >> {offset, 3'b000};
    case (op)
      MEM_OP_B:  return {{24{shifted[7]}}, shifted[7:0]};
      MEM_OP_H:  return {{16{shifted[15]}}, shifted[15:0]};
      MEM_OP_BU: return {24'd0, shifted[7:0]};
      MEM_OP_HU: return {16'd0, shifted[15:0]};
      default:   return shifted;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
#(
  parameter int RSP_DEPTH = 4
) (
  input  wire logic        clk,
  input  wire logic        rest,
  input  wire logic        req_valid,
  input  wire lsu_req_t    req,
  output logic             req_ready,
  output bus_cmd_t         bus_cmd,
  input  wire logic        bus_ready,
  input  wire logic        rsp_valid,
  input  wire logic [31:0] rsp_data,
  output logic             load_valid,
  output logic [31:0]      load_data
);

  logic        tag_push;
  load_tag_t   tag_in;
  load_tag_t   tag_out;
  logic        tag_empty;
  logic [31:0] rsp_word;
  logic        data_empty;
  logic        pop;
  logic        credit_return;

  lsu_cmd_gen #(
    .RSP_DEPTH     (RSP_DEPTH)
  ) u_cmd_gen (
    .clk           (clk),
    .rest          (rest),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .bus_cmd       (bus_cmd),
    .bus_ready     (bus_ready),
    .credit_return (credit_return),
    .tag_push      (tag_push),
    .tag           (tag_in)
  );

  lsu_fifo #(
    .payload_t     (load_tag_t),
    .DEPTH         (RSP_DEPTH)
  ) u_tag_fifo (
    .clk           (clk),
    .rest          (rest),
    .push          (tag_push),
    .push_data     (tag_in),
    .pop           (pop),
    .pop_data      (tag_out),
    .empty         (tag_empty)
  );

  // Responses cannot be stalled, so every beat is written straight in
  lsu_fifo #(
    .payload_t     (logic [31:0]),
    .DEPTH         (RSP_DEPTH)
  ) u_rsp_fifo (
    .clk           (clk),
    .rest          (rest),
    .push          (rsp_valid),
    .push_data     (rsp_data),
    .pop           (pop),
    .pop_data      (rsp_word),
    .empty         (data_empty)
  );

  lsu_load_align u_load_align (
    .clk           (clk),
    .rest          (rest),
    .tag_empty     (tag_empty),
    .tag           (tag_out),
    .data_empty    (data_empty),
    .rsp_word      (rsp_word),
    .pop           (pop),
    .credit_return (credit_return),
    .load_valid    (load_valid),
    .load_data     (load_data)
  );

endmodule

`default_nettype wire

// File: tb.f
design/lsu_pkg.sv
design/lsu_fifo.sv
design/lsu_cmd_gen.sv
design/lsu_load_align.sv
design/lsu_top.sv
testbench/lsu_checker.sv
testbench/lsu_tb.sv

// File: testbench/lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_checker
  import lsu_pkg::*;
#(
  parameter int          RSP_DEPTH = 4,
  parameter int          MEM_WORDS = 64,
  parameter logic [31:0] MEM_BASE  = 32'h0
) (
  input  wire logic        clk,
  input  wire logic        rest,
  input  wire logic        req_valid,
  input  wire lsu_req_t    req,
  input  wire logic        req_ready,
  input  wire bus_cmd_t    bus_cmd,
  input  wire logic        bus_ready,
  input  wire logic        load_valid,
  input  wire logic [31:0] load_data
);

  logic [31:0] ref_mem [MEM_WORDS];
  bus_cmd_t    exp_cmd_q [$];
  logic [31:0] exp_load_q [$];
  int          in_flight;
  int          max_in_flight;
  int          value_errors;
  int          protocol_errors;
  int          reset_edges;
  logic        rest_q;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = (MEM_BASE + 32'(4 * i)) ^ 32'h5a5a0000;
    end
    in_flight       = 0;
    max_in_flight   = 0;
    value_errors    = 0;
    protocol_errors = 0;
    reset_edges     = 0;
    rest_q          = 1'b0;
  end

  function automatic int access_size(mem_op_t op);
    if (op == MEM_OP_B || op == MEM_OP_BU) return 1;
    if (op == MEM_OP_H || op == MEM_OP_HU) return 2;
    return 4;
  endfunction

  function automatic logic [3:0] lanes_for(mem_op_t op, logic [1:0] off);
    logic [3:0] en;
    int         o;
    o = off;
    for (int b = 0; b < 4; b++) begin
      en[b] = (b >= o) && (b < o + access_size(op));
    end
    return en;
  endfunction

  function automatic logic [31:0] expand_lanes(logic [3:0] be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  // Gathers the accessed bytes into the low lanes, then fills the rest by sign or zero
  function automatic logic [31:0] predict_load(mem_op_t op, logic [1:0] off,
                                               logic [31:0] word);
    logic [31:0] val;
    int          o;
    int          sz;
    o   = off;
    sz  = access_size(op);
    val = '0;
    for (int i = 0; i < sz; i++) begin
      val[8*i +: 8] = word[8*(o+i) +: 8];
    end
    if ((op == MEM_OP_B || op == MEM_OP_H) && val[8*sz-1]) begin
      for (int b = 8 * sz; b < 32; b++) begin
        val[b] = 1'b1;
      end
    end
    return val;
  endfunction

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    value_errors++;
    $display("error %0t %s expected %h got %h", $time, name, expected, got);
  endtask

  task automatic protocol_error(input string what);
    protocol_errors++;
    $display("at %0t %s", $time, what);
  endtask

  always @(posedge clk) begin : monitor
    bus_cmd_t    exp;
    logic [31:0] exp_word;
    logic [31:0] mask;
    int          idx;
    if (!rest) begin
      reset_edges++;
      // The first edge is where the registers take their reset values
      if (reset_edges > 1) begin
        if (bus_cmd.read !== 1'b0 || bus_cmd.write !== 1'b0) begin
          protocol_error("bus command offered during reset");
        end
        if (load_valid !== 1'b0) protocol_error("load_valid high during reset");
      end
    end else begin
      if (!rest_q) begin
        if (bus_cmd.read !== 1'b0 || bus_cmd.write !== 1'b0) begin
          protocol_error("bus command offered right after reset");
        end
        if (load_valid !== 1'b0) protocol_error("load_valid high right after reset");
        if (req_ready !== 1'b1) value_error("req_ready", 32'd1, 32'(req_ready));
      end
      if (req_valid && req_ready) begin
        idx              = int'((req.addr - MEM_BASE) >> 2);
        exp.address      = MEM_BASE + 32'(4 * idx);
        exp.read         = !req.write;
        exp.write        = req.write;
        exp.byte_en      = lanes_for(req.op, req.addr[1:0]);
        exp.write_data   = '0;
        for (int i = 0; i < access_size(req.op); i++) begin
          exp.write_data[8*(req.addr[1:0]+i) +: 8] = req.wdata[8*i +: 8];
        end
        exp_cmd_q.push_back(exp);
        if (req.write) begin
          mask         = expand_lanes(exp.byte_en);
          ref_mem[idx] = (ref_mem[idx] & ~mask) | (exp.write_data & mask);
        end else begin
          exp_load_q.push_back(predict_load(req.op, req.addr[1:0], ref_mem[idx]));
          in_flight++;
        end
      end
      if ((bus_cmd.read || bus_cmd.write) && bus_ready) begin
        if (exp_cmd_q.size() == 0) begin
          protocol_error("bus accepted a command that no request asked for");
        end else begin
          exp  = exp_cmd_q.pop_front();
          mask = expand_lanes(exp.byte_en);
          if (bus_cmd.address !== exp.address) begin
            value_error("bus_cmd.address", exp.address, bus_cmd.address);
          end
          if (bus_cmd.read !== exp.read) value_error("bus_cmd.read", 32'(exp.read),
                                                     32'(bus_cmd.read));
          if (bus_cmd.write !== exp.write) value_error("bus_cmd.write", 32'(exp.write),
                                                       32'(bus_cmd.write));
          if (bus_cmd.byte_en !== exp.byte_en) begin
            value_error("bus_cmd.byte_en", 32'(exp.byte_en), 32'(bus_cmd.byte_en));
          end
          if (exp.write && (bus_cmd.write_data & mask) !== exp.write_data) begin
            value_error("bus_cmd.write_data", exp.write_data, bus_cmd.write_data & mask);
          end
        end
      end
      if (load_valid) begin
        if (exp_load_q.size() == 0) begin
          protocol_error("load_valid pulsed with no load outstanding");
        end else begin
          exp_word = exp_load_q.pop_front();
          if (load_data !== exp_word) value_error("load_data", exp_word, load_data);
          in_flight--;
        end
      end
      if (in_flight > max_in_flight) max_in_flight = in_flight;
      if (in_flight > RSP_DEPTH + 1) begin
        protocol_error($sformatf("%0d loads in flight, above the limit of %0d",
                                 in_flight, RSP_DEPTH + 1));
      end
    end
    rest_q = rest;
  end

  task automatic final_report(input int timeouts, output int total);
    if (exp_load_q.size() != 0) begin
      protocol_error($sformatf("%0d load results never arrived", exp_load_q.size()));
    end
    if (exp_cmd_q.size() != 0) begin
      protocol_error($sformatf("%0d commands never reached the bus", exp_cmd_q.size()));
    end
    if (max_in_flight != RSP_DEPTH + 1) begin
      protocol_error($sformatf("loads in flight peaked at %0d and never reached %0d",
                               max_in_flight, RSP_DEPTH + 1));
    end
    $display("checker summary: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errors, protocol_errors, timeouts);
    total = value_errors + protocol_errors + timeouts;
  endtask

endmodule

`default_nettype wire

// File: testbench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
();

  localparam int          RSP_DEPTH     = 4;
  localparam int          NUM_REQS      = 400;
  localparam int          MEM_WORDS     = 64;
  localparam logic [31:0] MEM_BASE      = 32'h0000_2000;
  localparam int          REQ_TIMEOUT   = 200;
  localparam int          DRAIN_TIMEOUT = 500;

  logic        clk;
  logic        rest;
  logic        req_valid;
  lsu_req_t    req;
  logic        req_ready;
  bus_cmd_t    bus_cmd;
  logic        bus_ready;
  logic        rsp_valid;
  logic [31:0] rsp_data;
  logic        load_valid;
  logic [31:0] load_data;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rd_data_q [$];
  int          rd_due_q [$];
  int          cycle_count;
  int          last_due;
  int          loads_accepted;
  int          loads_delivered;
  int          timeouts;
  int          total_errors;
  int          seed;
  int          first_rand;
  int          waited;
  bit          req_taken;
  bit          aborted;
  bit          burst;

  lsu_top #(.RSP_DEPTH(RSP_DEPTH)) i_lsu_top (
    .clk        (clk),
    .rest       (rest),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .bus_cmd    (bus_cmd),
    .bus_ready  (bus_ready),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

  lsu_checker #(
    .RSP_DEPTH  (RSP_DEPTH),
    .MEM_WORDS  (MEM_WORDS),
    .MEM_BASE   (MEM_BASE)
  ) u_checker (
    .clk        (clk),
    .rest       (rest),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .bus_cmd    (bus_cmd),
    .bus_ready  (bus_ready),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Takes the bus command at the edge and then drives the next inputs
  task automatic step_cycle();
    int widx;
    int due;
    @(posedge clk);
    cycle_count++;
    req_taken = req_valid && req_ready;
    if (req_taken && !req.write) loads_accepted++;
    if (load_valid) loads_delivered++;
    if ((bus_cmd.read || bus_cmd.write) && bus_ready) begin
      widx = int'((bus_cmd.address - MEM_BASE) >> 2);
      if (bus_cmd.write) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_cmd.byte_en[b]) mem[widx][8*b +: 8] = bus_cmd.write_data[8*b +: 8];
        end
      end else begin
        due = cycle_count + 1 + int'($urandom % 5);
        // Responses stay in order even when a later read draws a shorter delay
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rd_data_q.push_back(mem[widx]);
        rd_due_q.push_back(due);
      end
    end
    #2;
    bus_ready = ($urandom % 10) < 6;
    if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle_count) begin
      rsp_valid = 1'b1;
      rsp_data  = rd_data_q.pop_front();
      due       = rd_due_q.pop_front();
    end else begin
      rsp_valid = 1'b0;
    end
  endtask

  function automatic lsu_req_t random_request(input bit load_only);
    lsu_req_t   r;
    logic [1:0] off;
    r.write = load_only ? 1'b0 : (($urandom % 10) < 4);
    case ($urandom % 5)
      0:       r.op = MEM_OP_B;
      1:       r.op = MEM_OP_BU;
      2:       r.op = MEM_OP_H;
      3:       r.op = MEM_OP_HU;
      default: r.op = MEM_OP_W;
    endcase
    case (r.op)
      MEM_OP_B, MEM_OP_BU: off = 2'($urandom % 4);
      MEM_OP_H, MEM_OP_HU: off = {1'($urandom % 2), 1'b0};
      default:             off = 2'b00;
    endcase
    r.addr  = MEM_BASE + 32'(($urandom % MEM_WORDS) * 4) + 32'(off);
    r.wdata = $urandom;
    return r;
  endfunction

  task automatic send_request(input lsu_req_t r);
    int tries;
    req_valid = 1'b1;
    req       = r;
    req_taken = 1'b0;
    tries     = 0;
    while (!req_taken && tries < REQ_TIMEOUT) begin
      step_cycle();
      tries++;
    end
    if (!req_taken) begin
      $display("timeout: a request was not accepted within %0d cycles", REQ_TIMEOUT);
      timeouts++;
      aborted = 1'b1;
    end
  endtask

  initial begin
    rest            = 1'b0;
    req_valid       = 1'b0;
    req             = '0;
    bus_ready       = 1'b0;
    rsp_valid       = 1'b0;
    rsp_data        = '0;
    cycle_count     = 0;
    last_due        = 0;
    loads_accepted  = 0;
    loads_delivered = 0;
    timeouts        = 0;
    total_errors    = 0;
    aborted         = 1'b0;
    seed            = 32'h8f123ffa;
    first_rand      = $urandom(seed);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (MEM_BASE + 32'(4 * i)) ^ 32'h5a5a0000;
    end

    repeat (10) @(posedge clk);
    #2 rest = 1'b1;
    waited = 0;
    while (!req_ready && waited < 20) begin
      step_cycle();
      waited++;
    end
    if (!req_ready) begin
      $display("timeout: req_ready did not rise after reset");
      timeouts++;
      aborted = 1'b1;
    end

    // Requests 200 to 259 are back-to-back loads that use up every credit
    for (int n = 0; n < NUM_REQS && !aborted; n++) begin
      burst = (n >= 200) && (n < 260);
      if (!burst && ($urandom % 4) == 0) begin
        req_valid = 1'b0;
        repeat (1 + $urandom % 3) step_cycle();
      end
      send_request(random_request(burst));
    end
    req_valid = 1'b0;

    waited = 0;
    while (!aborted && loads_accepted != loads_delivered && waited < DRAIN_TIMEOUT) begin
      step_cycle();
      waited++;
    end
    if (!aborted && loads_accepted != loads_delivered) begin
      $display("timeout: %0d loads still had no result after the drain",
               loads_accepted - loads_delivered);
      timeouts++;
      aborted = 1'b1;
    end
    if (!aborted) repeat (10) step_cycle();

    u_checker.final_report(timeouts, total_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
